// File: glay_cfg.svh
/*
 * Vertex-reduction kernel configuration
 * Widths of the edge words, the word count and the byte lanes
 */

`ifndef GLAY_CFG_SVH
`define GLAY_CFG_SVH

// ----------------------------------------
// Datapath sizing
// ----------------------------------------

// Edge word and result value width
`define GLAY_DATA_W 32

// Word count carried in the descriptor
`define GLAY_COUNT_W 16

// Byte lanes per edge word, used by the swap
`define GLAY_BYTES 4

`endif

// File: glay_pkg.sv
/*
 * Shared types of the vertex-reduction kernel
 * Opcode and control state enums, descriptor, stream, result and
 * host status structs
 */

`include "glay_cfg.svh"

package glay_pkg;

    // ----------------------------------------
    // Enumerations
    // ----------------------------------------

    // Reduction opcodes
    typedef enum logic [1:0] {
        REDUCE_SUM = 2'd0,
        REDUCE_MAX = 2'd1,
        REDUCE_MIN = 2'd2,
        REDUCE_NZ  = 2'd3
    } reduce_op_e;

    // ap_ctrl_chain control states
    typedef enum logic [2:0] {
        CTRL_RESET = 3'd0,
        CTRL_IDLE  = 3'd1,
        CTRL_SETUP = 3'd2,
        CTRL_READY = 3'd3,
        CTRL_START = 3'd4,
        CTRL_BUSY  = 3'd5,
        CTRL_DONE  = 3'd6
    } ctrl_state_e;

    // ----------------------------------------
    // Descriptor and host control
    // ----------------------------------------

    typedef struct packed {
        reduce_op_e                opcode;
        logic                      endian;
        logic [`GLAY_COUNT_W-1:0]  count;
    } kernel_descriptor_t;

    // Descriptor as seen by the datapath
    typedef struct packed {
        logic               valid;
        kernel_descriptor_t payload;
    } descriptor_bus_t;

    typedef struct packed {
        logic ap_start;
    } ctrl_in_t;

    typedef struct packed {
        logic ap_ready;
        logic ap_done;
        logic ap_idle;
    } ctrl_out_t;

    // ----------------------------------------
    // Streams
    // ----------------------------------------

    typedef struct packed {
        logic [`GLAY_DATA_W-1:0] data;
    } edge_word_t;

    // Reduced value plus number of words consumed
    typedef struct packed {
        logic [`GLAY_DATA_W-1:0]  value;
        logic [`GLAY_COUNT_W-1:0] count;
    } reduce_result_t;

endpackage

// File: kernel_control.sv
/*
 * Kernel control
 * ap_ctrl_chain style state machine with registered ap_start,
 * state-decoded registered status and descriptor capture on job accept
 */

`timescale 1ns/10ps

module kernel_control (
    input  logic                         ap_clk,
    input  logic                         areset_control,
    input  glay_pkg::ctrl_in_t           control_in,
    output glay_pkg::ctrl_out_t          control_out,
    input  glay_pkg::kernel_descriptor_t descriptor_in,
    output glay_pkg::descriptor_bus_t    descriptor_out,
    input  logic                         engine_idle,
    input  logic                         result_taken
);

    import glay_pkg::*;

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    ctrl_state_e        state;
    ctrl_state_e        next_state;
    logic               ap_start_reg;
    logic               done_reg;
    logic               desc_valid_reg;
    kernel_descriptor_t desc_reg;

    // Host start and completion registered one cycle late
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            done_reg     <= 1'b0;
        end else begin
            ap_start_reg <= control_in.ap_start;
            done_reg     <= result_taken;
        end
    end

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            state <= CTRL_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CTRL_RESET: next_state = CTRL_IDLE;
            CTRL_IDLE:  next_state = CTRL_SETUP;
            // Wait for the host
            CTRL_SETUP: if (ap_start_reg) next_state = CTRL_READY;
            // Previous job must be fully drained
            CTRL_READY: if (engine_idle) next_state = CTRL_START;
            CTRL_START: next_state = CTRL_BUSY;
            CTRL_BUSY:  if (done_reg) next_state = CTRL_DONE;
            CTRL_DONE:  if (ap_start_reg) next_state = CTRL_READY;
            default:    next_state = CTRL_RESET;
        endcase
    end

    // Descriptor sampled on job acceptance
    always_ff @(posedge ap_clk) begin
        if ((state == CTRL_SETUP || state == CTRL_DONE) && ap_start_reg) begin
            desc_reg <= descriptor_in;
        end
    end

    // ----------------------------------------
    // Registered outputs from state
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            control_out    <= '{ap_ready: 1'b0, ap_done: 1'b0, ap_idle: 1'b1};
            desc_valid_reg <= 1'b0;
        end else begin
            case (state)
                CTRL_READY: begin
                    control_out    <= '{ap_ready: 1'b1, ap_done: 1'b0, ap_idle: 1'b0};
                    desc_valid_reg <= 1'b0;
                end
                // Datapath job window
                CTRL_START, CTRL_BUSY: begin
                    control_out    <= '{ap_ready: 1'b0, ap_done: 1'b0, ap_idle: 1'b0};
                    desc_valid_reg <= 1'b1;
                end
                CTRL_DONE: begin
                    control_out    <= '{ap_ready: 1'b0, ap_done: 1'b1, ap_idle: 1'b1};
                    desc_valid_reg <= 1'b0;
                end
                // Reset, idle and setup
                default: begin
                    control_out    <= '{ap_ready: 1'b0, ap_done: 1'b0, ap_idle: 1'b1};
                    desc_valid_reg <= 1'b0;
                end
            endcase
        end
    end

    assign descriptor_out = '{valid: desc_valid_reg, payload: desc_reg};

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    ready_done_exclusive: assert property (@(posedge ap_clk) disable iff (areset_control)
        !(control_out.ap_ready && control_out.ap_done));

    // Registered valid only seen in BUSY and the first DONE cycle
    desc_valid_in_job: assert property (@(posedge ap_clk) disable iff (areset_control)
        descriptor_out.valid |-> (state == CTRL_BUSY || state == CTRL_DONE));

endmodule

// File: edge_stream_aligner.sv
/*
 * Edge stream aligner
 * Single-entry valid/ready register slice, byte swap on the way in
 * when the descriptor asks for it
 */

`timescale 1ns/10ps

`include "glay_cfg.svh"

module edge_stream_aligner (
    input  logic                      ap_clk,
    input  logic                      areset_control,
    input  glay_pkg::descriptor_bus_t descriptor,
    input  glay_pkg::edge_word_t      in_word,
    input  logic                      in_valid,
    output logic                      in_ready,
    output glay_pkg::edge_word_t      out_word,
    output logic                      out_valid,
    input  logic                      out_ready
);

    import glay_pkg::*;

    // Reverse byte lanes
    function automatic edge_word_t byte_swap(input edge_word_t w);
        edge_word_t s;
        for (int b = 0; b < `GLAY_BYTES; b++) begin
            s.data[8*b +: 8] = w.data[8*(`GLAY_BYTES-1-b) +: 8];
        end
        return s;
    endfunction

    // Slot free or draining, and only inside a job
    assign in_ready = descriptor.valid && (!out_valid || out_ready);

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload, no reset
    always_ff @(posedge ap_clk) begin
        if (in_valid && in_ready) begin
            out_word <= descriptor.payload.endian ? byte_swap(in_word) : in_word;
        end
    end

    // Held word must not move under back-pressure
    out_stable: assert property (@(posedge ap_clk) disable iff (areset_control)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word)));

endmodule

// File: vertex_reduce_engine.sv
/*
 * Vertex reduce engine
 * Folds the descriptor's word count by opcode from the opcode identity,
 * pushes value and count, then stays busy until the result is taken
 */

`timescale 1ns/10ps

`include "glay_cfg.svh"

module vertex_reduce_engine (
    input  logic                      ap_clk,
    input  logic                      areset_control,
    input  glay_pkg::descriptor_bus_t descriptor,
    input  glay_pkg::edge_word_t      word,
    input  logic                      word_valid,
    output logic                      word_ready,
    output glay_pkg::reduce_result_t  result,
    output logic                      result_push,
    input  logic                      result_taken,
    output logic                      engine_idle
);

    import glay_pkg::*;

    logic                     desc_valid_d;
    logic                     job_load;
    logic                     busy;
    logic                     wait_taken;
    logic [`GLAY_DATA_W-1:0]  acc;
    logic [`GLAY_COUNT_W-1:0] counter;

    // ----------------------------------------
    // Opcode helpers
    // ----------------------------------------
    function automatic logic [`GLAY_DATA_W-1:0] identity(input reduce_op_e op);
        // Min starts from all ones, the rest from zero
        return (op == REDUCE_MIN) ? '1 : '0;
    endfunction

    function automatic logic [`GLAY_DATA_W-1:0] fold(
        input reduce_op_e              op,
        input logic [`GLAY_DATA_W-1:0] a,
        input logic [`GLAY_DATA_W-1:0] w
    );
        logic [`GLAY_DATA_W-1:0] r;
        case (op)
            REDUCE_SUM: r = a + w;
            REDUCE_MAX: r = (w > a) ? w : a;
            REDUCE_MIN: r = (w < a) ? w : a;
            default:    r = a + {{(`GLAY_DATA_W-1){1'b0}}, (w != '0)};
        endcase
        return r;
    endfunction

    // ----------------------------------------
    // Job sequencing
    // ----------------------------------------

    // New job on rising edge of descriptor valid
    assign job_load = descriptor.valid && !desc_valid_d;

    // Accept until the count is reached
    assign word_ready  = busy && (counter != descriptor.payload.count);
    // Count reached, result goes out this cycle
    assign result_push = busy && (counter == descriptor.payload.count);
    assign engine_idle = !busy && !wait_taken;
    assign result      = '{value: acc, count: counter};

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            desc_valid_d <= 1'b0;
            busy         <= 1'b0;
            wait_taken   <= 1'b0;
        end else begin
            desc_valid_d <= descriptor.valid;
            if (job_load) begin
                busy <= 1'b1;
            end else if (result_push) begin
                busy       <= 1'b0;
                wait_taken <= 1'b1;
            end else if (result_taken) begin
                wait_taken <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Accumulator and counter
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            counter <= '0;
        end else if (job_load) begin
            counter <= '0;
        end else if (word_valid && word_ready) begin
            counter <= counter + 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (job_load) begin
            acc <= identity(descriptor.payload.opcode);
        end else if (word_valid && word_ready) begin
            acc <= fold(descriptor.payload.opcode, acc, word.data);
        end
    end

    counter_bounded: assert property (@(posedge ap_clk) disable iff (areset_control)
        busy |-> (counter <= descriptor.payload.count));

endmodule

// File: result_port.sv
/*
 * Result port
 * One-entry output register, holds the result under back-pressure
 * and flags the accepting cycle back to control
 */

`timescale 1ns/10ps

module result_port (
    input  logic                     ap_clk,
    input  logic                     areset_control,
    input  glay_pkg::reduce_result_t result_in,
    input  logic                     push,
    output glay_pkg::reduce_result_t out_result,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     result_taken
);

    import glay_pkg::*;

    // Valid until the consumer takes it
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            out_valid <= 1'b0;
        end else if (push) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Held value
    always_ff @(posedge ap_clk) begin
        if (push) begin
            out_result <= result_in;
        end
    end

    // High only in the transfer cycle
    assign result_taken = out_valid && out_ready;

    // Engine must wait for the slot to drain
    no_push_when_full: assert property (@(posedge ap_clk) disable iff (areset_control)
        push |-> !out_valid);

endmodule

// File: kernel_top.sv
/*
 * Vertex-reduction kernel top level
 * Control block plus aligner, reduce engine and result port
 */

`timescale 1ns/10ps

module kernel_top (
    input  logic                         ap_clk,
    input  logic                         areset_control,
    input  glay_pkg::ctrl_in_t           control_in,
    output glay_pkg::ctrl_out_t          control_out,
    input  glay_pkg::kernel_descriptor_t descriptor_in,
    input  glay_pkg::edge_word_t         in_word,
    input  logic                         in_valid,
    output logic                         in_ready,
    output glay_pkg::reduce_result_t     out_result,
    output logic                         out_valid,
    input  logic                         out_ready
);

    import glay_pkg::*;

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    descriptor_bus_t descriptor;
    edge_word_t      aligned_word;
    logic            aligned_valid;
    logic            aligned_ready;
    reduce_result_t  engine_result;
    logic            result_push;
    logic            result_taken;
    logic            engine_idle;

    kernel_control kernel_control_inst (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .control_in     (control_in),
        .control_out    (control_out),
        .descriptor_in  (descriptor_in),
        .descriptor_out (descriptor),
        .engine_idle    (engine_idle),
        .result_taken   (result_taken)
    );

    // Input side
    edge_stream_aligner edge_stream_aligner_inst (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (descriptor),
        .in_word        (in_word),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_word       (aligned_word),
        .out_valid      (aligned_valid),
        .out_ready      (aligned_ready)
    );

    vertex_reduce_engine vertex_reduce_engine_inst (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (descriptor),
        .word           (aligned_word),
        .word_valid     (aligned_valid),
        .word_ready     (aligned_ready),
        .result         (engine_result),
        .result_push    (result_push),
        .result_taken   (result_taken),
        .engine_idle    (engine_idle)
    );

    // Output side
    result_port result_port_inst (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .result_in      (engine_result),
        .push           (result_push),
        .out_result     (out_result),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .result_taken   (result_taken)
    );

endmodule

// File: kernel_top_tb.sv
/*
 * Vertex-reduction kernel testbench
 * Loads descriptors, edge words and expected results from the test file,
 * runs every job with random input gaps and output stalls, checks the
 * result, the hold under back-pressure and the ap_ctrl_chain status
 */

`timescale 1ns/10ps

`include "glay_cfg.svh"

module kernel_top_tb;

    import glay_pkg::*;

    // Expected host status per phase
    localparam ctrl_out_t status_idle  = '{ap_ready: 1'b0, ap_done: 1'b0, ap_idle: 1'b1};
    localparam ctrl_out_t status_ready = '{ap_ready: 1'b1, ap_done: 1'b0, ap_idle: 1'b0};
    localparam ctrl_out_t status_busy  = '{ap_ready: 1'b0, ap_done: 1'b0, ap_idle: 1'b0};
    localparam ctrl_out_t status_done  = '{ap_ready: 1'b0, ap_done: 1'b1, ap_idle: 1'b1};

    logic               ap_clk = 1'b0;
    logic               areset_control;
    ctrl_in_t           control_in;
    ctrl_out_t          control_out;
    kernel_descriptor_t descriptor_in;
    edge_word_t         in_word;
    logic               in_valid;
    logic               in_ready;
    reduce_result_t     out_result;
    logic               out_valid;
    logic               out_ready;

    // Test file contents, words of all tests back to back
    string                   test_name[$];
    kernel_descriptor_t      test_desc[$];
    logic [`GLAY_DATA_W-1:0] test_value[$];
    int                      test_first[$];
    edge_word_t              word_list[$];
    int                      watchdog_cycles = 0;
    int                      tests_run = 0;

    kernel_top kernel_top_inst (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .control_in     (control_in),
        .control_out    (control_out),
        .descriptor_in  (descriptor_in),
        .in_word        (in_word),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_result     (out_result),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

    // 20 ns period
    always #10 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_result(input string name, input reduce_result_t expected,
                                input reduce_result_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf(
                "** Error: test %s result expected value %h count %0d, actual value %h count %0d",
                name, expected.value, expected.count, actual.value, actual.count));
        end
    endtask

    task automatic check_status(input string name, input ctrl_out_t expected,
                                input ctrl_out_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf(
                "** Error: test %s status expected ready/done/idle %b%b%b, actual %b%b%b",
                name, expected.ap_ready, expected.ap_done, expected.ap_idle,
                actual.ap_ready, actual.ap_done, actual.ap_idle));
        end
    endtask

    // ----------------------------------------
    // Test file loading
    // ----------------------------------------
    task automatic load_tests();
        int                      fd;
        int                      op_val;
        int                      endian_val;
        int                      count_val;
        int                      last;
        string                   line;
        string                   tag;
        string                   name;
        logic [`GLAY_DATA_W-1:0] hex_val;
        kernel_descriptor_t      desc;
        edge_word_t              item;
        fd = $fopen("kernel_tests.dat", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open kernel_tests.dat for reading");
        end
        while ($fgets(line, fd) != 0) begin
            // Blank and comment lines
            if ($sscanf(line, "%s", tag) != 1 || tag.substr(0, 0) == "#") begin
                continue;
            end
            if (tag == "test") begin
                if ($sscanf(line, "%s %s %d %d %d %h", tag, name, op_val, endian_val,
                            count_val, hex_val) != 6) begin
                    stop_with_failure({"Malformed test line in kernel_tests.dat: ", line});
                end
                desc.opcode = reduce_op_e'(op_val[1:0]);
                desc.endian = endian_val[0];
                desc.count  = count_val[`GLAY_COUNT_W-1:0];
                test_name.push_back(name);
                test_desc.push_back(desc);
                test_value.push_back(hex_val);
                test_first.push_back(word_list.size());
            end else if (tag == "word" && test_name.size() != 0) begin
                if ($sscanf(line, "%s %h", tag, hex_val) != 2) begin
                    stop_with_failure({"Malformed word line in kernel_tests.dat: ", line});
                end
                item.data = hex_val;
                word_list.push_back(item);
            end else begin
                stop_with_failure({"Unexpected line in kernel_tests.dat: ", line});
            end
        end
        $fclose(fd);
        // Each record needs exactly its descriptor count of words
        for (int i = 0; i < test_name.size(); i++) begin
            last = (i + 1 < test_name.size()) ? test_first[i + 1] : word_list.size();
            if (last - test_first[i] != int'(test_desc[i].count)) begin
                stop_with_failure({"Word count does not match descriptor in test ",
                                   test_name[i]});
            end
        end
    endtask

    // ----------------------------------------
    // One job from request to ap_done
    // ----------------------------------------
    task automatic run_test(input int t);
        reduce_result_t expected;
        reduce_result_t held_result;
        logic           held;
        logic           accepted;
        int             gap;
        int             last;
        expected = '{value: test_value[t], count: test_desc[t].count};
        held     = 1'b0;
        accepted = 1'b0;
        last     = test_first[t] + int'(test_desc[t].count);

        // Descriptor stays put until the next job
        descriptor_in       = test_desc[t];
        control_in.ap_start = 1'b1;
        while (!control_out.ap_ready) begin
            if (out_valid) begin
                stop_with_failure({"Result offered before ap_ready in test ", test_name[t]});
            end
            @(negedge ap_clk);
        end
        check_status(test_name[t], status_ready, control_out);
        control_in.ap_start = 1'b0;
        @(negedge ap_clk);

        // Edge words, random idle gaps between them
        for (int w = test_first[t]; w < last; w++) begin
            gap = int'($urandom % 4);
            repeat (gap) @(negedge ap_clk);
            in_word  = word_list[w];
            in_valid = 1'b1;
            // in_ready only depends on registers, stable here
            while (!in_ready) @(negedge ap_clk);
            @(negedge ap_clk);
            in_valid = 1'b0;
        end

        // Random out_ready, held result must not move
        while (!accepted) begin
            check_status(test_name[t], status_busy, control_out);
            if (out_valid) begin
                if (!held) begin
                    held        = 1'b1;
                    held_result = out_result;
                end else begin
                    check_result({test_name[t], "_hold"}, held_result, out_result);
                end
            end
            out_ready = ($urandom % 2 == 0);
            if (out_valid && out_ready) begin
                check_result(test_name[t], expected, out_result);
                accepted = 1'b1;
            end
            @(negedge ap_clk);
        end
        out_ready = 1'b0;
        if (out_valid) begin
            stop_with_failure({"out_valid still high after the result was taken in test ",
                               test_name[t]});
        end

        // ap_done and ap_idle come up together
        while (!control_out.ap_done) begin
            check_status(test_name[t], status_busy, control_out);
            @(negedge ap_clk);
        end
        check_status(test_name[t], status_done, control_out);
        tests_run++;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int unsigned seed_ret;
        control_in     = '0;
        descriptor_in  = '0;
        in_word        = '0;
        in_valid       = 1'b0;
        out_ready      = 1'b0;
        areset_control = 1'b1;
        seed_ret       = $urandom(32'he7e9);
        load_tests();
        watchdog_cycles = 200 + 20 * word_list.size();

        repeat (8) @(negedge ap_clk);
        areset_control = 1'b0;

        // Idle and quiet before any ap_start
        repeat (4) begin
            @(negedge ap_clk);
            check_status("after_reset", status_idle, control_out);
            if (in_ready !== 1'b0 || out_valid !== 1'b0) begin
                stop_with_failure("in_ready or out_valid raised before any job was started");
            end
        end

        for (int t = 0; t < test_name.size(); t++) begin
            run_test(t);
        end

        if (tests_run != 0 && tests_run == test_name.size()) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_failure("Not every test in kernel_tests.dat was run");
        end
    end

    // Run length bound from the number of words
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge ap_clk);
        stop_with_failure($sformatf("Timeout, the kernel did not finish within %0d cycles",
                                    watchdog_cycles));
    end

endmodule

// File: kernel_tests.dat
# test <name> <opcode 0 sum, 1 max, 2 min, 3 nz> <endian> <count> <expected value, hex>
# word <edge word, hex>, one line per word after its test line
test sum_plain 0 0 2 01000300
word 01000000
word 00000300
test sum_swap 0 1 2 00030001
word 01000000
word 00000300
test max_plain 1 0 2 80000001
word 7fff0000
word 80000001
test min_plain 2 0 2 00000fff
word 00001000
word 00000fff
test nz_plain 3 0 3 00000002
word 00000000
word 00000005
word ffffffff
test min_empty 2 0 0 ffffffff

// File: list.f
+incdir+.
glay_pkg.sv
kernel_control.sv
edge_stream_aligner.sv
vertex_reduce_engine.sv
result_port.sv
kernel_top.sv
kernel_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the kernel testbench with Verilator and run it
# The log is searched for the fail message to decide the result

rm -f sim.log

verilator --binary --assert -j 0 --top-module kernel_top_tb -f list.f -o kernel_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/kernel_sim > sim.log 2>&1
cat sim.log

grep -q "Verification failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation PASSED"
exit 0
